//--- Makefile
# Verilator build and run of the DMR stage testbench
VERILATOR  ?= verilator
TOP        := tb_dmr_pipe
FILELIST   := list.f
BUILD_DIR  := obj_dir
LOG        := sim.log
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/dmr_pkg.sv
// shared widths and payload structs for the DMR stage, imported by every RTL file
package dmr_pkg;

    // field widths
    localparam int unsigned DataBits  = 16;
    localparam int unsigned TagBits   = 4;
    localparam int unsigned ItemBits  = DataBits + TagBits;

    // fault counter width, saturates at all ones
    localparam int unsigned CountBits = 8;

    // data field of a stream item
    typedef logic [DataBits-1:0] data_t;

    // tag field, passes the lanes unchanged
    typedef logic [TagBits-1:0] tag_t;

    // stream item as seen on both handshake sides
    typedef struct packed {
        data_t data;
        tag_t  tag;
    } item_t;

    // registered result of one lane
    typedef struct packed {
        logic  hold;    // lane holds a result not yet consumed
        item_t item;
    } lane_res_t;

    // fault injection request from the testbench
    // lane 0 selects lane A, lane 1 selects lane B
    typedef struct packed {
        logic                strike;
        logic                lane;
        logic [ItemBits-1:0] mask;
    } fault_t;

    // number of detected mismatches
    typedef logic [CountBits-1:0] count_t;

endpackage

//--- dmr/dmr_compare.sv
// output stage of the DMR top, checks both lane results and commits or requests a replay
`timescale 1ns/1ps

module dmr_compare (
    // clock and reset
    input  logic               clk_i,
    input  logic               rst_ni,
    // lane results
    input  dmr_pkg::lane_res_t res_a_i,
    input  dmr_pkg::lane_res_t res_b_i,
    // output handshake
    output logic               valid_o,
    input  logic               ready_i,
    output dmr_pkg::item_t     item_o,
    // control back to buffer and lanes
    output logic               retry_o,
    output logic               clear_o,
    output logic               done_o,
    // fault reporting
    output logic               fault_o,
    output dmr_pkg::count_t    fault_count_o
);

    import dmr_pkg::*;

    // decision for the current cycle
    logic   both_hold;
    logic   same;
    logic   commit;
    logic   mismatch;

    // output register and fault state
    logic   valid_q;
    item_t  item_q;
    logic   fault_q;
    count_t count_d, count_q;

    // compare only with both results present and the output slot empty
    assign both_hold = res_a_i.hold & res_b_i.hold & ~valid_q;
    assign same      = (res_a_i.item == res_b_i.item);
    assign commit    = both_hold & same;
    assign mismatch  = both_hold & ~same;

    // lanes are consumed either way
    assign clear_o = commit | mismatch;
    assign retry_o = mismatch;

    // handshake edge frees the held input item
    assign done_o = valid_q & ready_i;

    // saturating fault counter
    always_comb begin
        count_d = count_q;
        if (mismatch && (count_q != '1)) begin
            count_d = count_q + 1'b1;
        end
    end

    // control registers
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
            fault_q <= 1'b0;
            count_q <= '0;
        end else begin
            if (commit) begin
                valid_q <= 1'b1;
            end else if (done_o) begin
                valid_q <= 1'b0;
            end
            // one cycle per mismatch
            fault_q <= mismatch;
            count_q <= count_d;
        end
    end

    // committed item, lane A taken as both agree
    always_ff @(posedge clk_i) begin
        if (commit) begin
            item_q <= res_a_i.item;
        end
    end

    assign valid_o       = valid_q;
    assign item_o        = item_q;
    assign fault_o       = fault_q;
    assign fault_count_o = count_q;

endmodule

//--- dmr/dmr_pipe.sv
// top of the DMR handshaked stage, replay buffer feeding two lanes and a comparator
`timescale 1ns/1ps

module dmr_pipe (
    // clock and reset
    input  logic            clk_i,
    input  logic            rst_ni,
    // input stream
    input  logic            valid_i,
    output logic            ready_o,
    input  dmr_pkg::item_t  item_i,
    // output stream
    output logic            valid_o,
    input  logic            ready_i,
    output dmr_pkg::item_t  item_o,
    // fault injection and reporting
    input  dmr_pkg::fault_t fault_i,
    output logic            fault_o,
    output dmr_pkg::count_t fault_count_o
);

    import dmr_pkg::*;

    // buffer to lanes
    logic      issue;
    item_t     issue_item;

    // lanes to comparator
    lane_res_t res_a;
    lane_res_t res_b;

    // comparator feedback
    logic      retry;
    logic      done;
    logic      clear;

    dmr_replay_buffer i_buffer (
        .clk_i        ( clk_i      ),
        .rst_ni       ( rst_ni     ),
        .valid_i      ( valid_i    ),
        .ready_o      ( ready_o    ),
        .item_i       ( item_i     ),
        .retry_i      ( retry      ),
        .done_i       ( done       ),
        .issue_o      ( issue      ),
        .issue_item_o ( issue_item )
    );

    // lane A
    dmr_lane #(
        .LaneIdx ( 1'b0 )
    ) i_lane_a (
        .clk_i        ( clk_i      ),
        .rst_ni       ( rst_ni     ),
        .issue_i      ( issue      ),
        .issue_item_i ( issue_item ),
        .clear_i      ( clear      ),
        .fault_i      ( fault_i    ),
        .res_o        ( res_a      )
    );

    // lane B
    dmr_lane #(
        .LaneIdx ( 1'b1 )
    ) i_lane_b (
        .clk_i        ( clk_i      ),
        .rst_ni       ( rst_ni     ),
        .issue_i      ( issue      ),
        .issue_item_i ( issue_item ),
        .clear_i      ( clear      ),
        .fault_i      ( fault_i    ),
        .res_o        ( res_b      )
    );

    dmr_compare i_compare (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .res_a_i       ( res_a         ),
        .res_b_i       ( res_b         ),
        .valid_o       ( valid_o       ),
        .ready_i       ( ready_i       ),
        .item_o        ( item_o        ),
        .retry_o       ( retry         ),
        .clear_o       ( clear         ),
        .done_o        ( done          ),
        .fault_o       ( fault_o       ),
        .fault_count_o ( fault_count_o )
    );

endmodule

//--- dmr/dmr_replay_buffer.sv
// input stage of the DMR top, keeps the accepted item and issues it to both lanes until commit
`timescale 1ns/1ps

module dmr_replay_buffer (
    // clock and reset
    input  logic           clk_i,
    input  logic           rst_ni,
    // input handshake
    input  logic           valid_i,
    output logic           ready_o,
    input  dmr_pkg::item_t item_i,
    // feedback from the comparator
    input  logic           retry_i,
    input  logic           done_i,
    // issue to both lanes
    output logic           issue_o,
    output dmr_pkg::item_t issue_item_o
);

    import dmr_pkg::*;

    // control state
    logic  full_d, full_q;
    logic  issue_d, issue_q;
    logic  accept;

    // held copy for replay
    item_t item_q;

    // one item in flight, so ready only while empty
    assign ready_o = ~full_q;
    assign accept  = valid_i & ready_o;

    always_comb begin
        // defaults
        full_d  = full_q;
        issue_d = 1'b0;

        // new item, issue in the next cycle
        if (accept) begin
            full_d  = 1'b1;
            issue_d = 1'b1;
        end

        // mismatch seen, reissue the held copy
        if (retry_i && full_q) begin
            issue_d = 1'b1;
        end

        // output handshake frees the slot
        if (done_i) begin
            full_d = 1'b0;
        end
    end

    // control registers
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q  <= 1'b0;
            issue_q <= 1'b0;
        end else begin
            full_q  <= full_d;
            issue_q <= issue_d;
        end
    end

    // held item
    // only written on accept, so a retry replays the same value
    always_ff @(posedge clk_i) begin
        if (accept) begin
            item_q <= item_i;
        end
    end

    // issue pulse and payload
    assign issue_o      = issue_q;
    assign issue_item_o = item_q;

endmodule

//--- list.f
common/dmr_pkg.sv
src/dmr_lane.sv
dmr/dmr_replay_buffer.sv
dmr/dmr_compare.sv
dmr/dmr_pipe.sv
tb/handshake_stream.sv
tb/dmr_pipe_assertions.sv
tb/tb_dmr_pipe.sv

//--- src/dmr_lane.sv
// one redundant compute lane, instantiated twice by the DMR top with its own lane index
`timescale 1ns/1ps

module dmr_lane #(
    parameter bit LaneIdx = 1'b0
) (
    // clock and reset
    input  logic               clk_i,
    input  logic               rst_ni,
    // issue from the replay buffer
    input  logic               issue_i,
    input  dmr_pkg::item_t     issue_item_i,
    // consume from the comparator
    input  logic               clear_i,
    // injected bit flips
    input  dmr_pkg::fault_t    fault_i,
    // registered result
    output dmr_pkg::lane_res_t res_o
);

    import dmr_pkg::*;

    // transform output and stored state
    data_t     sum_data;
    item_t     calc_item;
    logic      strike_hit;
    item_t     load_item;
    logic      hold_q;
    item_t     item_q;

    // data plus tag, wraps at DataBits
    assign sum_data = issue_item_i.data + data_t'(issue_item_i.tag);

    always_comb begin
        calc_item      = issue_item_i;
        calc_item.data = sum_data;
    end

    // strike only counts on the load edge and for this lane
    assign strike_hit = issue_i & fault_i.strike & (fault_i.lane == LaneIdx);

    // xor mask folded into the stored item
    assign load_item = strike_hit ? item_t'(calc_item ^ fault_i.mask) : calc_item;

    // holding flag
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hold_q <= 1'b0;
        end else if (issue_i) begin
            hold_q <= 1'b1;
        end else if (clear_i) begin
            // result taken or rejected by the comparator
            hold_q <= 1'b0;
        end
    end

    // result payload, loaded with the flag
    always_ff @(posedge clk_i) begin
        if (issue_i) begin
            item_q <= load_item;
        end
    end

    // flag and payload leave as one struct
    always_comb begin
        res_o.hold = hold_q;
        res_o.item = item_q;
    end

endmodule

//--- tb/dmr_pipe_assertions.sv
// concurrent checks on the DMR top handshakes and fault pulse, bound into dmr_pipe
`timescale 1ns/1ps

module dmr_pipe_assertions (
    input logic           clk_i,
    input logic           rst_ni,
    input logic           ready_o,
    input logic           valid_o,
    input logic           ready_i,
    input dmr_pkg::item_t item_o,
    input logic           fault_o
);

    // stalled output keeps valid and data
    stall_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (valid_o && !ready_i) |=> (valid_o && $stable(item_o)))
        else $error("valid_o or item_o changed while ready_i was low");

    // one pulse per mismatch
    fault_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fault_o |=> !fault_o)
        else $error("fault_o high for two cycles");

    // only one item in flight
    ready_while_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_o |-> !ready_o)
        else $error("ready_o high while valid_o is high");

    reset_state: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> (!valid_o && !fault_o))
        else $error("valid_o or fault_o set when leaving reset");

endmodule

bind dmr_pipe dmr_pipe_assertions i_assertions (
    .clk_i   ( clk_i   ),
    .rst_ni  ( rst_ni  ),
    .ready_o ( ready_o ),
    .valid_o ( valid_o ),
    .ready_i ( ready_i ),
    .item_o  ( item_o  ),
    .fault_o ( fault_o )
);

//--- tb/handshake_stream.sv
// counting stream source and ready-only stream sink, used by the DMR testbench as drivers
`timescale 1ns/1ps

module stream_source (
    input  logic           clk_i,
    input  logic           rst_ni,
    // request for the next item, ignored while one is pending
    input  logic           next_i,
    input  logic           allow_i,
    output logic           valid_o,
    input  logic           ready_i,
    output dmr_pkg::item_t item_o,
    // items generated since reset
    output logic [31:0]    count_o
);

    import dmr_pkg::*;

    logic fire;

    assign fire = valid_o & ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_o <= 1'b0;
            item_o  <= '0;
            count_o <= '0;
        end else if (next_i && allow_i && (!valid_o || fire)) begin
            // data counts up, tag is the low count bits
            valid_o     <= 1'b1;
            item_o.data <= data_t'(count_o);
            item_o.tag  <= tag_t'(count_o);
            count_o     <= count_o + 32'd1;
        end else if (fire) begin
            valid_o <= 1'b0;
        end
    end

endmodule

module stream_sink (
    input  logic        clk_i,
    input  logic        rst_ni,
    // raise ready, it drops again after one handshake
    input  logic        raise_i,
    input  logic        allow_i,
    input  logic        valid_i,
    output logic        ready_o,
    // items received since reset
    output logic [31:0] count_o
);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ready_o <= 1'b0;
            count_o <= '0;
        end else begin
            if (valid_i && ready_o) begin
                count_o <= count_o + 32'd1;
            end
            if (raise_i && allow_i) begin
                ready_o <= 1'b1;
            end else if (valid_i && ready_o) begin
                ready_o <= 1'b0;
            end
        end
    end

endmodule

//--- tb/tb_dmr_pipe.sv
// testbench top for the DMR stage that runs five stream tests against a reference model
`timescale 1ns/1ps

module tb_dmr_pipe;

    import dmr_pkg::*;

    // test sizes and the per item cycle bound for the watchdog
    localparam int ClkPeriod  = 8;
    localparam int NumItems   = 64;
    localparam int FaultItems = 4;
    localparam int ThrotItems = 32;
    localparam int TotalItems = 3 * NumItems + FaultItems + ThrotItems;
    localparam int MaxStrikes = 2;
    localparam int MaxReady   = 5;
    localparam int MaxGap     = 3;
    localparam int ItemCycles = 2 + 2 * MaxStrikes + MaxReady + MaxGap + 4;

    logic        clk_i = 1'b0;
    logic        rst_ni;
    // source, sink and DUT wiring
    logic        src_next = 1'b0;
    logic        src_allow = 1'b0;
    logic        snk_raise = 1'b0;
    logic        snk_allow = 1'b0;
    logic        src_valid, dut_ready, dut_valid, snk_ready, dut_fault;
    item_t       src_item, dut_item, exp_item;
    logic [31:0] src_count, snk_count;
    fault_t      fault = '0;
    count_t      fault_count;
    // modes set by the main sequence
    int          target = 0;
    int          fmode = 0;
    bit          throttle = 1'b0;
    bit          backpressure = 1'b0;
    // falling edge driver state
    integer      seed = 32'h043d_ccc1;
    int          gap = 0;
    int          rdelay = 0;
    int          item_strikes = 0;
    int          strikes = 0;
    bit          single_done = 1'b0;
    // rising edge monitor state
    logic        in_fire = 1'b0;
    bit          held = 1'b0;
    bit          valid_prev = 1'b0;
    int          cyc = 0;
    int          in_cyc = 0;
    int          rx_idx = 0;
    int          pulses = 0;
    int          mon_errors = 0;
    int          end_errors = 0;
    int          total_rx = 0;

    always #(ClkPeriod / 2) clk_i = ~clk_i;

    stream_source i_source (
        .clk_i   ( clk_i     ),
        .rst_ni  ( rst_ni    ),
        .next_i  ( src_next  ),
        .allow_i ( src_allow ),
        .valid_o ( src_valid ),
        .ready_i ( dut_ready ),
        .item_o  ( src_item  ),
        .count_o ( src_count )
    );

    dmr_pipe dut (
        .clk_i         ( clk_i       ),
        .rst_ni        ( rst_ni      ),
        .valid_i       ( src_valid   ),
        .ready_o       ( dut_ready   ),
        .item_i        ( src_item    ),
        .valid_o       ( dut_valid   ),
        .ready_i       ( snk_ready   ),
        .item_o        ( dut_item    ),
        .fault_i       ( fault       ),
        .fault_o       ( dut_fault   ),
        .fault_count_o ( fault_count )
    );

    stream_sink i_sink (
        .clk_i   ( clk_i     ),
        .rst_ni  ( rst_ni    ),
        .raise_i ( snk_raise ),
        .allow_i ( snk_allow ),
        .valid_i ( dut_valid ),
        .ready_o ( snk_ready ),
        .count_o ( snk_count )
    );

    // n-th source item after the lanes is data plus tag with wrap
    function automatic item_t expected_item(input int n);
        item_t res;
        res.tag  = tag_t'(n);
        res.data = data_t'(n) + data_t'(res.tag);
        return res;
    endfunction

    // one strike with a nonzero mask on the given lane
    task automatic strike_lane(input logic lane);
        logic [ItemBits-1:0] mask;
        mask = ItemBits'($random(seed));
        if (mask == '0) begin
            mask = ItemBits'(1);
        end
        fault.strike = 1'b1;
        fault.lane   = lane;
        fault.mask   = mask;
        strikes++;
        item_strikes++;
    endtask

    always @(negedge clk_i) begin
        // source requests with random gaps when throttled
        src_allow = (src_count < target);
        if (gap > 0) begin
            src_next = 1'b0;
            gap--;
        end else begin
            src_next = 1'b1;
            if (throttle && src_allow) begin
                gap = int'($unsigned($random(seed)) % (MaxGap + 1));
            end
        end
        // sink ready after a random delay under back-pressure
        if (!backpressure) begin
            snk_raise = 1'b1;
            snk_allow = 1'b1;
        end else if (dut_valid && !snk_ready) begin
            // raise held back until the delay has run out
            snk_raise = 1'b1;
            snk_allow = (rdelay == 0);
            if (rdelay > 0) begin
                rdelay--;
            end else begin
                rdelay = int'($unsigned($random(seed)) % (MaxReady + 1));
            end
        end else begin
            snk_raise = 1'b0;
            snk_allow = 1'b0;
        end
        // strikes only in issue cycles after a handshake or with a fault pulse
        fault = '0;
        if (fmode != 1) begin
            single_done = 1'b0;
        end
        if (in_fire) begin
            item_strikes = 0;
        end
        if (fmode == 1 && in_fire && !single_done) begin
            strike_lane(1'b1);
            single_done = 1'b1;
        end else if (fmode == 2 && in_fire && $unsigned($random(seed)) % 3 == 0) begin
            strike_lane(1'($random(seed)));
        end else if (fmode == 2 && dut_fault && item_strikes < MaxStrikes
                     && $unsigned($random(seed)) % 2 == 0) begin
            // hits the replayed load of the same item
            strike_lane(1'($random(seed)));
        end
    end

    // compares outputs and handshake timing with values sampled before the edge updates
    always @(posedge clk_i) begin
        cyc++;
        if (!rst_ni) begin
            in_fire <= 1'b0;
            held = 1'b0;
            valid_prev = 1'b0;
            rx_idx = 0;
        end else begin
            in_fire <= src_valid & dut_ready;
            assert (held || dut_ready) else begin
                $display("ERROR at %0t: ready_o low while no item is held", $time);
                mon_errors++;
            end
            if (src_valid && dut_ready) begin
                held = 1'b1;
                in_cyc = cyc;
            end
            // seen three samples on means valid rose two edges after the handshake
            if (dut_valid && !valid_prev && fmode == 0) begin
                assert (cyc - in_cyc == 3) else begin
                    $display("ERROR at %0t: valid_o rose %0d cycles after input",
                             $time, cyc - in_cyc - 1);
                    mon_errors++;
                end
            end
            valid_prev = dut_valid;
            if (dut_fault) begin
                pulses++;
            end
            if (dut_valid && snk_ready) begin
                exp_item = expected_item(rx_idx);
                assert (dut_item == exp_item) else begin
                    $display("ERROR at %0t: output %0d is %h/%h, expected %h/%h", $time,
                             rx_idx, dut_item.data, dut_item.tag, exp_item.data, exp_item.tag);
                    mon_errors++;
                end
                rx_idx++;
                held = 1'b0;
            end
        end
    end

    task automatic apply_reset();
        rst_ni = 1'b0;
        repeat (4) begin
            @(posedge clk_i);
        end
        @(negedge clk_i);
        rst_ni = 1'b1;
        assert (!dut_valid && !dut_fault && fault_count == '0) else begin
            $display("ERROR at %0t: after reset valid %b fault %b count %0d", $time,
                     dut_valid, dut_fault, fault_count);
            end_errors++;
        end
        #(ClkPeriod / 4);
    endtask

    task automatic run_test(input int num, input string name, input int n);
        int          err0, strikes0, pulses0, count0;
        logic [31:0] rx0;
        err0     = mon_errors + end_errors;
        strikes0 = strikes;
        pulses0  = pulses;
        count0   = int'(fault_count);
        rx0      = snk_count;
        target   = target + n;
        while (rx_idx < target) begin
            @(negedge clk_i);
        end
        // every strike gives one count and one pulse
        assert (int'(fault_count) - count0 == strikes - strikes0
                && pulses - pulses0 == strikes - strikes0) else begin
            $display("ERROR at %0t: fault count rose %0d, %0d pulses, %0d strikes", $time,
                     int'(fault_count) - count0, pulses - pulses0, strikes - strikes0);
            end_errors++;
        end
        assert (int'(snk_count - rx0) == n) else begin
            $display("ERROR at %0t: received %0d items, sent %0d", $time,
                     int'(snk_count - rx0), n);
            end_errors++;
        end
        total_rx += n;
        $display("test %0d %s: %0d items, %0d strikes, %s", num, name, n,
                 strikes - strikes0, (mon_errors + end_errors == err0) ? "ok" : "errors");
        #(ClkPeriod / 4);
    endtask

    initial begin
        apply_reset();
        run_test(1, "ordered stream", NumItems);
        backpressure = 1'b1;
        run_test(2, "back-pressure", NumItems);
        backpressure = 1'b0;
        fmode = 1;
        run_test(3, "single fault in lane B", FaultItems);
        fmode = 2;
        run_test(4, "random faults in both lanes", NumItems);
        fmode = 0;
        throttle = 1'b1;
        target = 0;
        apply_reset();
        run_test(5, "throttled input after reset", ThrotItems);
        $display("done: %0d items, %0d strikes, %0d errors", total_rx, strikes,
                 mon_errors + end_errors);
        if (mon_errors + end_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // bound on the run from the item count and the worst case per item
    initial begin
        #((TotalItems * ItemCycles + 200) * ClkPeriod);
        $display("timeout: the tests did not complete in the expected time");
        $display("TEST FAILED");
        $finish;
    end

endmodule
